//--- include/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// requester side
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4

// one AXI4-Lite data beat holds two requester words
`define BUS_AXI_DATA_W 64
`define BUS_AXI_STRB_W 8

// core timer, mtime low word sits at the base
`define BUS_CLINT_BASE 32'h0200_bff8
`define BUS_CLINT_HI_OFS 32'h0000_0004

// console byte register
`define BUS_UART_ADDR 32'h1000_0000

`endif

//--- design/axi_lite_pkg.sv
`include "bus_cfg.svh"

package axi_lite_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // AXI size is log2 of the byte count
  typedef enum logic [2:0] {
    SIZE_1B = 3'b000,
    SIZE_2B = 3'b001,
    SIZE_4B = 3'b010
  } size_t;

  typedef struct packed {
    logic [`BUS_DATA_W-1:0] hi;
    logic [`BUS_DATA_W-1:0] lo;
  } lanes_t;

  // a beat seen whole on the bus, or as two 32-bit lanes by the core side
  typedef union packed {
    logic [`BUS_AXI_DATA_W-1:0] beat;
    lanes_t                     lane;
  } beat_u;

endpackage

//--- design/bus_map_pkg.sv
package bus_map_pkg;

  // where a granted address lands
  typedef enum logic [1:0] {
    MEM   = 2'd0,
    CLINT = 2'd1,
    UART  = 2'd2
  } target_e;

  // who gets the read data back
  typedef enum logic {
    IFU      = 1'b0,
    LSU_LOAD = 1'b1
  } requester_e;

endpackage

//--- design/bus_addr_decode.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_addr_decode (
  input  logic [`BUS_ADDR_W-1:0] addr_i,
  input  logic [`BUS_STRB_W-1:0] strb_i,
  output bus_map_pkg::target_e   target_o,
  output axi_lite_pkg::size_t    size_o
);

  logic clint_lo;
  logic clint_hi;

  // mtime is visible as two adjacent words
  assign clint_lo = (addr_i == `BUS_CLINT_BASE);
  assign clint_hi = (addr_i == `BUS_CLINT_BASE + `BUS_CLINT_HI_OFS);

  always_comb
  begin
    if (clint_lo || clint_hi)
      target_o = bus_map_pkg::CLINT;
    else if (addr_i == `BUS_UART_ADDR)
      target_o = bus_map_pkg::UART;
    else
      target_o = bus_map_pkg::MEM;
  end

  // byte and halfword strobes may sit anywhere inside the word
  always_comb
  begin
    case (strb_i)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: size_o = axi_lite_pkg::SIZE_1B;
      4'b0011, 4'b0110, 4'b1100:          size_o = axi_lite_pkg::SIZE_2B;
      default:                            size_o = axi_lite_pkg::SIZE_4B;
    endcase
  end

endmodule

//--- design/bus_arbiter_exec.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_arbiter_exec (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          ifu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0]        ifu_araddr_i,
  input  logic                          lsu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0]        lsu_araddr_i,
  input  logic                          lsu_awvalid_i,
  input  logic [`BUS_ADDR_W-1:0]        lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0]        lsu_wdata_i,
  input  logic [`BUS_STRB_W-1:0]        lsu_wstrb_i,
  input  bus_map_pkg::target_e          ld_target_i,
  input  axi_lite_pkg::size_t           ld_size_i,
  input  bus_map_pkg::target_e          st_target_i,
  input  axi_lite_pkg::size_t           st_size_i,
  output logic [`BUS_ADDR_W-1:0]        m_araddr_o,
  output axi_lite_pkg::size_t           m_arsize_o,
  output logic                          m_arvalid_o,
  input  logic                          m_arready_i,
  input  logic [1:0]                    m_rresp_i,
  input  logic                          m_rvalid_i,
  output logic                          m_rready_o,
  output logic [`BUS_ADDR_W-1:0]        m_awaddr_o,
  output axi_lite_pkg::size_t           m_awsize_o,
  output logic                          m_awvalid_o,
  input  logic                          m_awready_i,
  output logic [`BUS_AXI_DATA_W-1:0]    m_wdata_o,
  output logic [`BUS_AXI_STRB_W-1:0]    m_wstrb_o,
  output logic                          m_wvalid_o,
  input  logic                          m_wready_i,
  input  logic [1:0]                    m_bresp_i,
  input  logic                          m_bvalid_i,
  output logic                          m_bready_o,
  output logic                          clint_rd_o,
  output logic                          clint_hi_o,
  output logic                          uart_we_o,
  output logic [7:0]                    uart_byte_o,
  output logic                          done_o,
  output logic                          wr_o,
  output bus_map_pkg::requester_e       owner_o,
  output bus_map_pkg::target_e          target_o,
  output logic                          lane_hi_o,
  output axi_lite_pkg::resp_t           resp_o,
  output logic                          lsu_wready_o
);

  typedef enum logic [2:0] {
    S_IDLE, S_RADDR, S_RDATA, S_WRITE, S_WRESP, S_LRD, S_LWR
  } state_e;

  state_e                  state_q;
  logic                    cpl_q;
  logic                    aw_pend_q;
  logic                    w_pend_q;
  logic                    wr_q;
  logic [`BUS_ADDR_W-1:0]  addr_q;
  logic [`BUS_DATA_W-1:0]  wdata_q;
  logic [`BUS_STRB_W-1:0]  wstrb_q;
  axi_lite_pkg::size_t     size_q;
  bus_map_pkg::requester_e owner_q;
  bus_map_pkg::target_e    target_q;
  axi_lite_pkg::beat_u     wbeat;
  logic                    grant;
  logic                    aw_left;
  logic                    w_left;

  // cpl_q keeps the requester one cycle to drop its valid
  assign grant = (state_q == S_IDLE) && !cpl_q &&
                 (lsu_awvalid_i || lsu_arvalid_i || ifu_arvalid_i);
  assign aw_left = aw_pend_q && !m_awready_i;
  assign w_left  = w_pend_q && !m_wready_i;

  // request latch, store beats load beats fetch
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      if (lsu_awvalid_i)
      begin
        addr_q   <= lsu_awaddr_i;
        size_q   <= st_size_i;
        owner_q  <= bus_map_pkg::LSU_LOAD;
        target_q <= (st_target_i == bus_map_pkg::UART) ? bus_map_pkg::UART : bus_map_pkg::MEM;
        wdata_q  <= lsu_wdata_i;
        wstrb_q  <= lsu_wstrb_i;
      end
      else if (lsu_arvalid_i)
      begin
        addr_q   <= lsu_araddr_i;
        size_q   <= ld_size_i;
        owner_q  <= bus_map_pkg::LSU_LOAD;
        target_q <= (ld_target_i == bus_map_pkg::CLINT) ? bus_map_pkg::CLINT : bus_map_pkg::MEM;
      end
      else
      begin
        addr_q   <= ifu_araddr_i;
        size_q   <= axi_lite_pkg::SIZE_4B;
        owner_q  <= bus_map_pkg::IFU;
        target_q <= bus_map_pkg::MEM;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= S_IDLE;
      cpl_q        <= 1'b0;
      aw_pend_q    <= 1'b0;
      w_pend_q     <= 1'b0;
      wr_q         <= 1'b0;
      lsu_wready_o <= 1'b0;
    end
    else
    begin
      cpl_q        <= done_o;
      lsu_wready_o <= done_o && wr_q;
      case (state_q)
        S_IDLE:
        begin
          if (grant)
          begin
            wr_q <= lsu_awvalid_i;
            if (lsu_awvalid_i && st_target_i == bus_map_pkg::UART)
              state_q <= S_LWR;
            else if (lsu_awvalid_i)
            begin
              state_q   <= S_WRITE;
              aw_pend_q <= 1'b1;
              w_pend_q  <= 1'b1;
            end
            else if (lsu_arvalid_i && ld_target_i == bus_map_pkg::CLINT)
              state_q <= S_LRD;
            else
              state_q <= S_RADDR;
          end
        end
        S_RADDR:
          if (m_arready_i)
            state_q <= S_RDATA;
        S_RDATA:
          if (m_rvalid_i)
            state_q <= S_IDLE;
        S_WRITE:
        begin
          // AW and W are accepted independently
          aw_pend_q <= aw_left;
          w_pend_q  <= w_left;
          if (!aw_left && !w_left)
            state_q <= S_WRESP;
        end
        S_WRESP:
          if (m_bvalid_i)
            state_q <= S_IDLE;
        default:
          state_q <= S_IDLE;
      endcase
    end
  end

  // 32-bit store data goes on the lane picked by address bit 2
  always_comb
  begin
    wbeat.lane.lo = lane_hi_o ? '0 : wdata_q;
    wbeat.lane.hi = lane_hi_o ? wdata_q : '0;
  end

  assign lane_hi_o = addr_q[2];

  assign m_araddr_o  = addr_q;
  assign m_arsize_o  = size_q;
  assign m_arvalid_o = (state_q == S_RADDR);
  assign m_rready_o  = 1'b1;
  assign m_awaddr_o  = addr_q;
  assign m_awsize_o  = size_q;
  assign m_awvalid_o = (state_q == S_WRITE) && aw_pend_q;
  assign m_wdata_o   = wbeat.beat;
  assign m_wstrb_o   = lane_hi_o ? {wstrb_q, {`BUS_STRB_W{1'b0}}} : {{`BUS_STRB_W{1'b0}}, wstrb_q};
  assign m_wvalid_o  = (state_q == S_WRITE) && w_pend_q;
  assign m_bready_o  = 1'b1;

  assign clint_rd_o  = (state_q == S_LRD);
  assign clint_hi_o  = (addr_q == `BUS_CLINT_BASE + `BUS_CLINT_HI_OFS);
  assign uart_we_o   = (state_q == S_LWR);
  assign uart_byte_o = wdata_q[7:0];

  // completion is seen here one cycle ahead of the requester pulse
  assign done_o = (state_q == S_RDATA && m_rvalid_i) || (state_q == S_WRESP && m_bvalid_i) ||
                  (state_q == S_LRD) || (state_q == S_LWR);
  assign wr_o     = wr_q;
  assign owner_o  = owner_q;
  assign target_o = target_q;

  always_comb
  begin
    if (state_q == S_WRESP)
      resp_o = axi_lite_pkg::resp_t'(m_bresp_i);
    else if (state_q == S_RDATA)
      resp_o = axi_lite_pkg::resp_t'(m_rresp_i);
    else
      resp_o = axi_lite_pkg::OKAY;
  end

endmodule

//--- design/bus_read_result.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_read_result (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    done_i,
  input  logic                    wr_i,
  input  bus_map_pkg::requester_e owner_i,
  input  bus_map_pkg::target_e    target_i,
  input  logic                    lane_hi_i,
  input  axi_lite_pkg::resp_t     resp_i,
  input  axi_lite_pkg::beat_u     m_rdata_i,
  input  logic [`BUS_DATA_W-1:0]  clint_rdata_i,
  output logic [`BUS_DATA_W-1:0]  ifu_rdata_o,
  output logic                    ifu_rvalid_o,
  output logic [`BUS_DATA_W-1:0]  lsu_rdata_o,
  output logic                    lsu_rvalid_o,
  output logic                    bus_err_o
);

  axi_lite_pkg::beat_u     beat_q;
  bus_map_pkg::requester_e owner_q;
  logic                    clint_q;
  logic                    lane_hi_q;
  logic                    rd_done;
  logic [`BUS_DATA_W-1:0]  rd_word;

  assign rd_done = done_i && !wr_i;

  // beat captured on the R handshake
  always_ff @(posedge clk)
  begin
    if (rd_done)
    begin
      beat_q    <= m_rdata_i;
      lane_hi_q <= lane_hi_i;
      clint_q   <= (target_i == bus_map_pkg::CLINT);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_q      <= bus_map_pkg::IFU;
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      bus_err_o    <= 1'b0;
    end
    else
    begin
      if (rd_done)
        owner_q <= owner_i;
      ifu_rvalid_o <= rd_done && (owner_i == bus_map_pkg::IFU);
      lsu_rvalid_o <= rd_done && (owner_i == bus_map_pkg::LSU_LOAD);
      bus_err_o    <= done_i && (resp_i != axi_lite_pkg::OKAY);
    end
  end

  // timer word is already registered in the CLINT by now
  assign rd_word = clint_q ? clint_rdata_i : (lane_hi_q ? beat_q.lane.hi : beat_q.lane.lo);

  assign ifu_rdata_o = (owner_q == bus_map_pkg::IFU) ? rd_word : '0;
  assign lsu_rdata_o = (owner_q == bus_map_pkg::LSU_LOAD) ? rd_word : '0;

endmodule

//--- design/bus_clint.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_clint (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_i,
  input  logic                   hi_i,
  output logic [`BUS_DATA_W-1:0] rdata_o
);

  logic [2*`BUS_DATA_W-1:0] mtime_q;

  // free running, no compare
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + 1'b1;
  end

  // word valid the cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_o <= hi_i ? mtime_q[2*`BUS_DATA_W-1:`BUS_DATA_W] : mtime_q[`BUS_DATA_W-1:0];
  end

endmodule

//--- design/bus_uart_tx.sv
`timescale 1ns/1ps

module bus_uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       we_i,
  input  logic [7:0] byte_i,
  output logic       tx_valid_o,
  output logic [7:0] tx_data_o
);

  // one pulse per accepted store
  always_ff @(posedge clk)
  begin
    if (rst)
      tx_valid_o <= 1'b0;
    else
      tx_valid_o <= we_i;
  end

  // last byte stays visible after the pulse
  always_ff @(posedge clk)
  begin
    if (we_i)
      tx_data_o <= byte_i;
  end

endmodule

//--- design/bus_arbiter_top.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_arbiter_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ifu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0]     ifu_araddr_i,
  output logic [`BUS_DATA_W-1:0]     ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  input  logic                       lsu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0]     lsu_araddr_i,
  input  logic [`BUS_STRB_W-1:0]     lsu_rstrb_i,
  output logic [`BUS_DATA_W-1:0]     lsu_rdata_o,
  output logic                       lsu_rvalid_o,
  input  logic                       lsu_awvalid_i,
  input  logic [`BUS_ADDR_W-1:0]     lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0]     lsu_wdata_i,
  input  logic [`BUS_STRB_W-1:0]     lsu_wstrb_i,
  output logic                       lsu_wready_o,
  output logic [`BUS_ADDR_W-1:0]     m_araddr_o,
  output logic [2:0]                 m_arsize_o,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic [`BUS_AXI_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]                 m_rresp_i,
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  output logic [`BUS_ADDR_W-1:0]     m_awaddr_o,
  output logic [2:0]                 m_awsize_o,
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic [`BUS_AXI_DATA_W-1:0] m_wdata_o,
  output logic [`BUS_AXI_STRB_W-1:0] m_wstrb_o,
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  input  logic [1:0]                 m_bresp_i,
  input  logic                       m_bvalid_i,
  output logic                       m_bready_o,
  output logic                       uart_tx_valid_o,
  output logic [7:0]                 uart_tx_data_o,
  output logic                       bus_err_o
);

  bus_map_pkg::target_e    ld_target;
  bus_map_pkg::target_e    st_target;
  axi_lite_pkg::size_t     ld_size;
  axi_lite_pkg::size_t     st_size;
  logic                    done;
  logic                    wr;
  bus_map_pkg::requester_e owner;
  bus_map_pkg::target_e    target;
  logic                    lane_hi;
  axi_lite_pkg::resp_t     resp;
  logic                    clint_rd;
  logic                    clint_hi;
  logic [`BUS_DATA_W-1:0]  clint_rdata;
  logic                    uart_we;
  logic [7:0]              uart_byte;

  bus_addr_decode ld_dec_i (
    .addr_i   (lsu_araddr_i),
    .strb_i   (lsu_rstrb_i),
    .target_o (ld_target),
    .size_o   (ld_size)
  );

  bus_addr_decode st_dec_i (
    .addr_i   (lsu_awaddr_i),
    .strb_i   (lsu_wstrb_i),
    .target_o (st_target),
    .size_o   (st_size)
  );

  bus_arbiter_exec exec_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .ld_target_i   (ld_target),
    .ld_size_i     (ld_size),
    .st_target_i   (st_target),
    .st_size_i     (st_size),
    .m_araddr_o    (m_araddr_o),
    .m_arsize_o    (m_arsize_o),
    .m_arvalid_o   (m_arvalid_o),
    .m_arready_i   (m_arready_i),
    .m_rresp_i     (m_rresp_i),
    .m_rvalid_i    (m_rvalid_i),
    .m_rready_o    (m_rready_o),
    .m_awaddr_o    (m_awaddr_o),
    .m_awsize_o    (m_awsize_o),
    .m_awvalid_o   (m_awvalid_o),
    .m_awready_i   (m_awready_i),
    .m_wdata_o     (m_wdata_o),
    .m_wstrb_o     (m_wstrb_o),
    .m_wvalid_o    (m_wvalid_o),
    .m_wready_i    (m_wready_i),
    .m_bresp_i     (m_bresp_i),
    .m_bvalid_i    (m_bvalid_i),
    .m_bready_o    (m_bready_o),
    .clint_rd_o    (clint_rd),
    .clint_hi_o    (clint_hi),
    .uart_we_o     (uart_we),
    .uart_byte_o   (uart_byte),
    .done_o        (done),
    .wr_o          (wr),
    .owner_o       (owner),
    .target_o      (target),
    .lane_hi_o     (lane_hi),
    .resp_o        (resp),
    .lsu_wready_o  (lsu_wready_o)
  );

  bus_read_result result_i (
    .clk           (clk),
    .rst           (rst),
    .done_i        (done),
    .wr_i          (wr),
    .owner_i       (owner),
    .target_i      (target),
    .lane_hi_i     (lane_hi),
    .resp_i        (resp),
    .m_rdata_i     (m_rdata_i),
    .clint_rdata_i (clint_rdata),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .bus_err_o     (bus_err_o)
  );

  bus_clint clint_i (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (clint_rd),
    .hi_i    (clint_hi),
    .rdata_o (clint_rdata)
  );

  bus_uart_tx uart_i (
    .clk        (clk),
    .rst        (rst),
    .we_i       (uart_we),
    .byte_i     (uart_byte),
    .tx_valid_o (uart_tx_valid_o),
    .tx_data_o  (uart_tx_data_o)
  );

endmodule

//--- test/tb_bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module tb_bus_arbiter;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 6;
  // worst case per transaction, with the memory delays capped at 7 cycles
  localparam int WORST_LAT  = 40;
  localparam int TXN_PER_TEST = 8;
  localparam logic [31:0] ERR_ADDR = 32'h0000_03f0;

  logic        clk;
  logic        rst;
  logic        ifu_arvalid_i;
  logic [31:0] ifu_araddr_i;
  logic [31:0] ifu_rdata_o;
  logic        ifu_rvalid_o;
  logic        lsu_arvalid_i;
  logic [31:0] lsu_araddr_i;
  logic [3:0]  lsu_rstrb_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rvalid_o;
  logic        lsu_awvalid_i;
  logic [31:0] lsu_awaddr_i;
  logic [31:0] lsu_wdata_i;
  logic [3:0]  lsu_wstrb_i;
  logic        lsu_wready_o;
  logic [31:0] m_araddr_o;
  logic [2:0]  m_arsize_o;
  logic        m_arvalid_o;
  logic        m_arready_i;
  logic [63:0] m_rdata_i;
  logic [1:0]  m_rresp_i;
  logic        m_rvalid_i;
  logic        m_rready_o;
  logic [31:0] m_awaddr_o;
  logic [2:0]  m_awsize_o;
  logic        m_awvalid_o;
  logic        m_awready_i;
  logic [63:0] m_wdata_o;
  logic [7:0]  m_wstrb_o;
  logic        m_wvalid_o;
  logic        m_wready_i;
  logic [1:0]  m_bresp_i;
  logic        m_bvalid_i;
  logic        m_bready_o;
  logic        uart_tx_valid_o;
  logic [7:0]  uart_tx_data_o;
  logic        bus_err_o;

  int          errors;
  int          seed;
  int          cyc;
  int          uart_pulses;
  logic [7:0]  exp_uart_byte;
  logic [63:0] mem [0:255];
  int          ar_wait;
  int          aw_wait;
  int          w_wait;
  logic        aw_got;
  logic        w_got;
  logic [31:0] aw_addr_q;
  logic [63:0] w_data_q;
  logic [7:0]  w_strb_q;

  bus_arbiter_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fill pattern built from the byte address of each word
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0] ^ 16'ha5c3, ~addr[15:0]};
  endfunction

  function automatic logic [2:0] strobe_size(input logic [3:0] strb);
    int ones;
    ones = strb[0] + strb[1] + strb[2] + strb[3];
    if (ones == 1)
      return 3'd0;
    else if (ones == 2)
      return 3'd1;
    return 3'd2;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];
    return res;
  endfunction

  task automatic report_fail(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // AXI4-Lite memory with random ready delays
  always @(posedge clk)
  begin
    if (rst)
    begin
      m_arready_i <= 1'b0;
      m_rvalid_i  <= 1'b0;
      m_awready_i <= 1'b0;
      m_wready_i  <= 1'b0;
      m_bvalid_i  <= 1'b0;
      m_rresp_i   <= 2'b00;
      m_bresp_i   <= 2'b00;
      m_rdata_i   <= '0;
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      ar_wait     <= 2;
      aw_wait     <= 1;
      w_wait      <= 3;
    end
    else
    begin
      if (m_rvalid_i)
        m_rvalid_i <= 1'b0;
      if (m_arvalid_o && m_arready_i)
      begin
        m_arready_i <= 1'b0;
        m_rvalid_i  <= 1'b1;
        m_rdata_i   <= mem[m_araddr_o[10:3]];
        m_rresp_i   <= (m_araddr_o == ERR_ADDR) ? 2'b10 : 2'b00;
        ar_wait     <= $random(seed) & 7;
      end
      else if (m_arvalid_o)
      begin
        if (ar_wait == 0)
          m_arready_i <= 1'b1;
        else
          ar_wait <= ar_wait - 1;
      end

      if (m_awvalid_o && m_awready_i)
      begin
        m_awready_i <= 1'b0;
        aw_got      <= 1'b1;
        aw_addr_q   <= m_awaddr_o;
        aw_wait     <= $random(seed) & 3;
      end
      else if (m_awvalid_o)
      begin
        if (aw_wait == 0)
          m_awready_i <= 1'b1;
        else
          aw_wait <= aw_wait - 1;
      end

      if (m_wvalid_o && m_wready_i)
      begin
        m_wready_i <= 1'b0;
        w_got      <= 1'b1;
        w_data_q   <= m_wdata_o;
        w_strb_q   <= m_wstrb_o;
        w_wait     <= $random(seed) & 3;
      end
      else if (m_wvalid_o)
      begin
        if (w_wait == 0)
          m_wready_i <= 1'b1;
        else
          w_wait <= w_wait - 1;
      end

      if (m_bvalid_i)
        m_bvalid_i <= 1'b0;
      if (aw_got && w_got)
      begin
        for (int b = 0; b < 8; b++)
          if (w_strb_q[b])
            mem[aw_addr_q[10:3]][8*b +: 8] = w_data_q[8*b +: 8];
        aw_got     <= 1'b0;
        w_got      <= 1'b0;
        m_bvalid_i <= 1'b1;
        m_bresp_i  <= 2'b00;
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      cyc         <= 0;
      uart_pulses <= 0;
    end
    else
    begin
      cyc <= cyc + 1;
      if (uart_tx_valid_o)
        uart_pulses <= uart_pulses + 1;
    end
  end

  // outputs quiet right after reset
  reset_quiet: assert property (@(posedge clk) $past(rst) |-> !m_arvalid_o && !m_awvalid_o &&
      !m_wvalid_o && !ifu_rvalid_o && !lsu_rvalid_o && !lsu_wready_o && !uart_tx_valid_o &&
      !bus_err_o)
    else report_fail("an output was high right after reset");

  wstrb_lane: assert property (@(posedge clk) disable iff (rst)
      m_wvalid_o |-> (m_awaddr_o[2] ? m_wstrb_o[3:0] == 4'h0 : m_wstrb_o[7:4] == 4'h0))
    else report_fail("write strobe set on the wrong lane");

  aw_size: assert property (@(posedge clk) disable iff (rst)
      m_awvalid_o |-> m_awsize_o == strobe_size(lsu_wstrb_i))
    else report_fail("AXI write size does not match the store strobe");

  // fetches are always whole words
  ar_size: assert property (@(posedge clk) disable iff (rst)
      m_arvalid_o |-> m_arsize_o == (lsu_arvalid_i ? strobe_size(lsu_rstrb_i) : 3'd2))
    else report_fail("AXI read size does not match the request");

  ready_held: assert property (@(posedge clk) disable iff (rst)
      m_rready_o && m_bready_o)
    else report_fail("rready or bready was not held high");

  uart_no_axi: assert property (@(posedge clk) disable iff (rst)
      m_awvalid_o |-> m_awaddr_o != `BUS_UART_ADDR)
    else report_fail("console store reached the AXI write channel");

  // idle arbiter grants on the first cycle of the store request
  uart_pulse: assert property (@(posedge clk) disable iff (rst)
      uart_tx_valid_o |-> lsu_wready_o && uart_tx_data_o == exp_uart_byte &&
      $past(lsu_awvalid_i, 2) && !$past(lsu_awvalid_i, 3))
    else report_fail("console pulse has wrong byte or timing");

  clint_no_axi: assert property (@(posedge clk) disable iff (rst)
      m_arvalid_o |-> m_araddr_o != `BUS_CLINT_BASE)
    else report_fail("timer read reached the AXI read channel");

  rvalid_excl: assert property (@(posedge clk) disable iff (rst)
      !(ifu_rvalid_o && lsu_rvalid_o))
    else report_fail("fetch and load completed on the same cycle");

  ar_stable: assert property (@(posedge clk) disable iff (rst)
      m_arvalid_o && $past(m_arvalid_o) && !$past(m_arready_i) |->
      m_araddr_o == $past(m_araddr_o))
    else report_fail("read address changed while waiting for arready");

  err_pulse: assert property (@(posedge clk) disable iff (rst)
      lsu_rvalid_o |-> bus_err_o == (lsu_araddr_i == ERR_ADDR))
    else report_fail("bus_err_o does not match the response of the load");

  err_with_cpl: assert property (@(posedge clk) disable iff (rst)
      bus_err_o |-> lsu_rvalid_o || ifu_rvalid_o || lsu_wready_o)
    else report_fail("bus_err_o pulsed without a completion");

  task automatic write_lsu(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(posedge clk);
    lsu_awvalid_i <= 1'b1;
    lsu_awaddr_i  <= addr;
    lsu_wdata_i   <= data;
    lsu_wstrb_i   <= strb;
    @(negedge clk);
    while (!lsu_wready_o)
      @(negedge clk);
    @(posedge clk);
    lsu_awvalid_i <= 1'b0;
  endtask

  task automatic read_lsu(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= addr;
    lsu_rstrb_i   <= 4'hf;
    @(negedge clk);
    while (!lsu_rvalid_o)
      @(negedge clk);
    data = lsu_rdata_o;
    err  = bus_err_o;
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
  endtask

  task automatic fetch_instr(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    ifu_arvalid_i <= 1'b1;
    ifu_araddr_i  <= addr;
    @(negedge clk);
    while (!ifu_rvalid_o)
      @(negedge clk);
    data = ifu_rdata_o;
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
  endtask

  task automatic test_done(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d failed checks", num, name, errors - errs_before);
  endtask

  initial
  begin
    #(NUM_TESTS * TXN_PER_TEST * WORST_LAT * CLK_PERIOD);
    $display("timeout: a transaction never completed");
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] rd;
    logic [31:0] rd2;
    logic [31:0] exp;
    logic        err;
    int          e0;
    time         t_lsu;
    time         t_ifu;

    errors        = 0;
    seed          = 88636;
    exp_uart_byte = 8'h00;
    for (int i = 0; i < 256; i++)
      mem[i] = {fill_word(i * 8 + 4), fill_word(i * 8)};
    rst           = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_rstrb_i   = 4'h0;
    lsu_awvalid_i = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = 4'h0;
    m_arready_i   = 1'b0;
    m_rvalid_i    = 1'b0;
    m_rdata_i     = '0;
    m_rresp_i     = 2'b00;
    m_awready_i   = 1'b0;
    m_wready_i    = 1'b0;
    m_bvalid_i    = 1'b0;
    m_bresp_i     = 2'b00;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    e0 = errors;
    write_lsu(32'h100, 32'hdead_beef, 4'hf);
    write_lsu(32'h104, 32'hcafe_f00d, 4'hf);
    read_lsu(32'h100, rd, err);
    check_val("lane lo word", 32'hdead_beef, rd);
    read_lsu(32'h104, rd, err);
    check_val("lane hi word", 32'hcafe_f00d, rd);
    test_done(1, "word store and load", e0);

    e0 = errors;
    write_lsu(32'h200, 32'h1122_3344, 4'hf);
    write_lsu(32'h200, 32'h0000_ab00, 4'b0010);
    write_lsu(32'h200, 32'hcdef_0000, 4'b1100);
    exp = merge(merge(32'h1122_3344, 32'h0000_ab00, 4'b0010), 32'hcdef_0000, 4'b1100);
    read_lsu(32'h200, rd, err);
    check_val("sub-word lo", exp, rd);
    write_lsu(32'h20c, 32'h0000_0077, 4'b0001);
    read_lsu(32'h20c, rd, err);
    check_val("byte hi lane", merge(fill_word(32'h20c), 32'h77, 4'b0001), rd);
    test_done(2, "byte and halfword stores", e0);

    e0 = errors;
    exp_uart_byte = 8'h41;
    write_lsu(`BUS_UART_ADDR, 32'h1234_5641, 4'hf);
    @(negedge clk);
    check_val("console pulses", 32'd1, uart_pulses);
    test_done(3, "console store", e0);

    e0 = errors;
    read_lsu(`BUS_CLINT_BASE, rd, err);
    assert (rd < cyc)
    else
      report_fail("first timer value not below the elapsed cycle count");
    read_lsu(`BUS_CLINT_BASE, rd2, err);
    assert (rd2 > rd && rd2 < cyc)
    else
      report_fail("second timer value not increasing or too large");
    test_done(4, "timer reads", e0);

    e0 = errors;
    t_lsu = 0;
    t_ifu = 0;
    fork
      begin
        read_lsu(32'h104, rd, err);
        t_lsu = $time;
      end
      begin
        fetch_instr(32'h300, rd2);
        t_ifu = $time;
      end
    join
    check_val("load data", 32'hcafe_f00d, rd);
    check_val("fetch data", fill_word(32'h300), rd2);
    assert (t_lsu < t_ifu)
    else
      report_fail("fetch finished before the tied load");
    test_done(5, "fetch and load tie", e0);

    e0 = errors;
    read_lsu(ERR_ADDR, rd, err);
    check_val("error flag", 32'd1, {31'd0, err});
    read_lsu(32'h100, rd, err);
    check_val("no error flag", 32'd0, {31'd0, err});
    test_done(6, "error response", e0);

    repeat (4) @(posedge clk);
    $display("tests run %0d, failed checks %0d", NUM_TESTS, errors);
    if (errors == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
design/axi_lite_pkg.sv
design/bus_map_pkg.sv
design/bus_addr_decode.sv
design/bus_arbiter_exec.sv
design/bus_read_result.sv
design/bus_clint.sv
design/bus_uart_tx.sv
design/bus_arbiter_top.sv
test/tb_bus_arbiter.sv

//--- run.sh
#!/bin/sh
# build and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_bus_arbiter \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
